// File: spi_wb_pkg.sv
package spi_wb_pkg;

  // Widest register address the bus can carry
  localparam int WB_ADR_W = 4;
  localparam int WB_DAT_W = 8;

  // Reply codes on MISO
  localparam logic [7:0] BYTE_IDLE = 8'h00;  // Filler, access still running
  localparam logic [7:0] BYTE_DONE = 8'hFF;  // Access finished

  // Master to slave
  typedef struct packed {
    logic                stb;  // Held until ack
    logic                we;   // 1 for write
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;  // Write data
  } wb_ctrl_t;

  // Slave to master
  typedef struct packed {
    logic                ack;  // One cycle per access
    logic [WB_DAT_W-1:0] dat;  // Read data, valid with ack
  } wb_peri_t;

  // Command decoder states
  //
  // Read frame
  //   MOSI  W000SSSS  AAAAAAAA  00000000 ...  00000000  00000000
  //   MISO  ........  00000000  00000000 ...  11111111  DDDDDDDD
  //
  // Write frame
  //   MOSI  W000SSSS  AAAAAAAA  DDDDDDDD  00000000 ...
  //   MISO  ........  00000000  00000000  00000000 ...  11111111
  //
  // SSSS size nibble is received and ignored
  typedef enum logic [2:0] {
    StIdle,           // Waiting for a non-zero command byte
    StGetAddress,     // Next byte is the address
    StWaitAck,        // Read on the bus
    StReadData,       // Next reply carries the read byte
    StWriteData,      // Next byte is the write data
    StWriteStallAck   // Write on the bus
  } ctrl_state_e;

endpackage

// File: spi_byte_slave.sv
module spi_byte_slave (
  input  logic       clk_i,
  input  logic       rst_ni,

  // SPI pins, mode 0, MSB first
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,

  // Byte side
  output logic [7:0] rx_data,
  output logic       rx_stb,
  input  logic [7:0] tx_data,
  input  logic       tx_stb
);

  // Two-stage synchronizer on {sclk, cs_n, mosi}
  logic [2:0] pin_meta;
  logic [2:0] pin_sync;
  logic       sclk_prev;  // Delayed sclk_s for edge detect

  logic       sclk_s;
  logic       cs_n_s;
  logic       mosi_s;
  logic       sclk_rise;
  logic       sclk_fall;

  logic [2:0] bit_cnt;    // Rising edges seen in current byte
  logic [7:0] tx_shreg;   // Reply shifter, MSB on the pin

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pin_meta  <= 3'b010;  // Deselected, clock low
      pin_sync  <= 3'b010;
      sclk_prev <= 1'b0;
    end else begin
      pin_meta  <= {sclk, cs_n, mosi};
      pin_sync  <= pin_meta;
      sclk_prev <= sclk_s;
    end
  end

  assign {sclk_s, cs_n_s, mosi_s} = pin_sync;

  // Edges only count while selected
  assign sclk_rise = sclk_s & ~sclk_prev & ~cs_n_s;
  assign sclk_fall = ~sclk_s & sclk_prev & ~cs_n_s;

  // Receive side
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bit_cnt <= 3'd0;
      rx_stb  <= 1'b0;
    end else begin
      rx_stb <= 1'b0;
      if (cs_n_s) begin
        bit_cnt <= 3'd0;  // Realign on every deselect
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;  // Wraps to 0 after bit 7
        rx_stb  <= (bit_cnt == 3'd7);  // Eighth bit in
      end
    end
  end

  // MOSI is stable at the rising edge, shift it in MSB first
  always_ff @(posedge clk_i) begin
    if (sclk_rise) begin
      rx_data <= {rx_data[6:0], mosi_s};
    end
  end

  // Transmit side
  //
  // The reply is loaded one cycle after rx_stb, well before the next
  // byte's first rising edge, so its MSB is already on MISO when the
  // master samples it. The falling edge that closes a byte arrives after
  // the load and must not shift, hence the bit_cnt guard
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      tx_shreg <= 8'h00;
    end else if (tx_stb) begin
      tx_shreg <= tx_data;  // Next reply
    end else if (cs_n_s) begin
      tx_shreg <= 8'h00;  // Quiet line when deselected
    end else if (sclk_fall && (bit_cnt != 3'd0)) begin
      tx_shreg <= {tx_shreg[6:0], 1'b0};  // Present next bit
    end
  end

  assign miso = tx_shreg[7];

endmodule

// File: wb_cmd_ctrl.sv
module wb_cmd_ctrl #(
  parameter int ADDR_W = 4  // Register address bits actually decoded
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Wishbone master side
  output spi_wb_pkg::wb_ctrl_t wb_c,
  input  spi_wb_pkg::wb_peri_t wb_p,

  // Byte stream from and to the SPI slave
  input  logic [7:0]           rx_data,
  input  logic                 rx_stb,
  output logic [7:0]           tx_data,
  output logic                 tx_stb
);

  // Keeps only the low ADDR_W bits of the address byte
  localparam logic [spi_wb_pkg::WB_ADR_W-1:0] ADR_MASK =
    '1 >> (spi_wb_pkg::WB_ADR_W - ADDR_W);

  spi_wb_pkg::ctrl_state_e state;

  logic                            stb_q;
  logic                            we_q;   // W bit of the command byte
  logic [spi_wb_pkg::WB_ADR_W-1:0] adr_q;
  logic [7:0]                      wdat_q;
  logic [7:0]                      rdat_q; // Captured at ack

  assign wb_c = '{stb: stb_q, we: we_q, adr: adr_q, dat: wdat_q};

  // Sequencing and bus handshake
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state  <= spi_wb_pkg::StIdle;
      stb_q  <= 1'b0;
      we_q   <= 1'b0;
      tx_stb <= 1'b0;
    end else begin
      tx_stb <= rx_stb;  // One reply per received byte
      if (wb_p.ack) begin
        stb_q <= 1'b0;  // Drop in the cycle after ack
      end
      if (rx_stb) begin
        case (state)
          spi_wb_pkg::StIdle: begin
            we_q <= rx_data[7];
            if (rx_data != spi_wb_pkg::BYTE_IDLE) begin
              state <= spi_wb_pkg::StGetAddress;  // Fillers are skipped
            end
          end
          spi_wb_pkg::StGetAddress: begin
            if (we_q) begin
              state <= spi_wb_pkg::StWriteData;  // Need the data byte first
            end else begin
              stb_q <= 1'b1;  // Read starts right away
              state <= spi_wb_pkg::StWaitAck;
            end
          end
          spi_wb_pkg::StWaitAck:
            if (!stb_q) state <= spi_wb_pkg::StReadData;
          spi_wb_pkg::StReadData:
            state <= spi_wb_pkg::StIdle;
          spi_wb_pkg::StWriteData: begin
            stb_q <= 1'b1;
            state <= spi_wb_pkg::StWriteStallAck;
          end
          spi_wb_pkg::StWriteStallAck:
            if (!stb_q) state <= spi_wb_pkg::StIdle;
          default:
            state <= spi_wb_pkg::StIdle;
        endcase
      end
    end
  end

  // Payload and reply bytes
  always_ff @(posedge clk_i) begin
    if (wb_p.ack) begin
      rdat_q <= wb_p.dat;  // Only meaningful for reads
    end
    if (rx_stb) begin
      case (state)
        spi_wb_pkg::StGetAddress: begin
          adr_q   <= rx_data[spi_wb_pkg::WB_ADR_W-1:0] & ADR_MASK;
          tx_data <= spi_wb_pkg::BYTE_IDLE;
        end
        spi_wb_pkg::StWriteData: begin
          wdat_q  <= rx_data;
          tx_data <= spi_wb_pkg::BYTE_IDLE;
        end
        spi_wb_pkg::StWaitAck, spi_wb_pkg::StWriteStallAck:
          // Done marker once ack has cleared stb
          tx_data <= stb_q ? spi_wb_pkg::BYTE_IDLE : spi_wb_pkg::BYTE_DONE;
        spi_wb_pkg::StReadData:
          tx_data <= rdat_q;
        default:
          tx_data <= spi_wb_pkg::BYTE_IDLE;
      endcase
    end
  end

endmodule

// File: wb_reg_bank.sv
module wb_reg_bank #(
  parameter int ADDR_W    = 4,
  parameter int ACK_DELAY = 3   // Wait cycles before ack
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  spi_wb_pkg::wb_ctrl_t wb_c,
  output spi_wb_pkg::wb_peri_t wb_p
);

  localparam int NUM_REGS = 2 ** ADDR_W;
  localparam int CNT_W    = (ACK_DELAY > 0) ? $clog2(ACK_DELAY + 1) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ACK_DELAY);

  logic [7:0]        regs [NUM_REGS];
  logic [CNT_W-1:0]  wait_cnt;
  logic              done_q;  // Access served, wait for stb low
  logic              ack_q;
  logic [7:0]        rdat_q;
  logic [ADDR_W-1:0] idx;
  logic              fire;    // Access completes this cycle

  assign idx  = wb_c.adr[ADDR_W-1:0];
  assign fire = wb_c.stb && !done_q && (wait_cnt == CNT_LAST);

  // Ack timing, ack lands ACK_DELAY+1 cycles after stb rises
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wait_cnt <= '0;
      done_q   <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= fire;
      if (!wb_c.stb) begin
        wait_cnt <= '0;  // Rearm only between accesses
        done_q   <= 1'b0;
      end else if (fire) begin
        wait_cnt <= '0;
        done_q   <= 1'b1;  // Blocks a second ack
      end else if (!done_q) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // Register storage
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (fire && wb_c.we) begin
      regs[idx] <= wb_c.dat;
    end
  end

  // Read data goes out together with ack
  always_ff @(posedge clk_i) begin
    if (fire) begin
      rdat_q <= regs[idx];
    end
  end

  assign wb_p = '{ack: ack_q, dat: rdat_q};

endmodule

// File: spi_wb_top.sv
module spi_wb_top #(
  parameter int ADDR_W    = 4,
  parameter int ACK_DELAY = 3
) (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  // Byte link
  logic [7:0] rx_data;
  logic       rx_stb;
  logic [7:0] tx_data;
  logic       tx_stb;

  // Bus
  spi_wb_pkg::wb_ctrl_t wb_c;
  spi_wb_pkg::wb_peri_t wb_p;

  spi_byte_slave u_spi (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso),
    .rx_data (rx_data),
    .rx_stb  (rx_stb),
    .tx_data (tx_data),
    .tx_stb  (tx_stb)
  );

  wb_cmd_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wb_c    (wb_c),
    .wb_p    (wb_p),
    .rx_data (rx_data),
    .rx_stb  (rx_stb),
    .tx_data (tx_data),
    .tx_stb  (tx_stb)
  );

  wb_reg_bank #(.ADDR_W(ADDR_W), .ACK_DELAY(ACK_DELAY)) u_regs (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wb_c   (wb_c),
    .wb_p   (wb_p)
  );

endmodule

// File: tb_spi_wb_checker.sv
module tb_spi_wb_checker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  input  logic miso,
  output int   value_errs,
  output int   proto_errs,
  output int   reads_checked
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_FILLERS = 8;  // Completion marker must show up by then

  // Frame position as seen from the pins
  typedef enum logic [2:0] {ChkIdle, ChkAddr, ChkWdata, ChkWait, ChkRdata} chk_state_e;
  // What the reply to the current byte must look like
  typedef enum logic [1:0] {KindIdle, KindWait, KindData} reply_kind_e;

  chk_state_e  state;
  reply_kind_e exp_kind;
  logic [7:0]  model [16];  // Register model, low 4 address bits
  logic [7:0]  mosi_sr;
  logic [7:0]  miso_sr;
  logic [3:0]  addr;
  logic [7:0]  wdata;
  logic        cur_w;  // Frame is a write
  logic        sclk_q;
  int          bit_cnt;
  int          fillers;  // Idle replies while waiting for the bus

  task automatic value_error(input string what, input logic [7:0] exp, input logic [7:0] act);
    value_errs++;
    $display("[ERROR] %0d ns: %s expected 0x%02h got 0x%02h", $time, what, exp, act);
  endtask

  // r is the reply to the previous byte, m the byte just shifted in
  task automatic handle_byte(input logic [7:0] m, input logic [7:0] r);
    case (exp_kind)
      KindIdle: begin
        if (r != spi_wb_pkg::BYTE_IDLE) value_error("filler reply", spi_wb_pkg::BYTE_IDLE, r);
      end
      KindWait: begin
        if (r == spi_wb_pkg::BYTE_DONE) begin
          if (cur_w) begin
            model[addr] = wdata;  // Write has been acknowledged
            state = ChkIdle;
          end else begin
            state = ChkRdata;  // This byte fetches the data
          end
        end else if (r != spi_wb_pkg::BYTE_IDLE) begin
          value_error("wait reply", spi_wb_pkg::BYTE_IDLE, r);
        end else begin
          fillers++;
          if (fillers == MAX_FILLERS + 1) begin
            proto_errs++;
            $display("At %0d ns no completion byte came within %0d filler bytes",
                     $time, MAX_FILLERS);
          end
        end
      end
      KindData: begin
        reads_checked++;
        if (r != model[addr]) value_error($sformatf("read data at reg %0d", addr), model[addr], r);
      end
      default: ;
    endcase

    case (state)
      ChkIdle: begin
        exp_kind = KindIdle;
        if (m != 8'h00) begin  // Zero bytes are skipped
          cur_w = m[7];
          state = ChkAddr;
        end
      end
      ChkAddr: begin
        addr     = m[3:0];  // Upper bits alias
        exp_kind = KindIdle;
        fillers  = 0;
        state    = cur_w ? ChkWdata : ChkWait;
      end
      ChkWdata: begin
        wdata    = m;
        exp_kind = KindIdle;
        state    = ChkWait;
      end
      ChkWait: exp_kind = KindWait;
      ChkRdata: begin
        exp_kind = KindData;
        state    = ChkIdle;
      end
      default: state = ChkIdle;
    endcase
  endtask

  // Pins are sampled on clk_i, values from before the edge
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      state         = ChkIdle;
      exp_kind      = KindIdle;
      bit_cnt       = 0;
      fillers       = 0;
      cur_w         = 1'b0;
      value_errs    = 0;
      proto_errs    = 0;
      reads_checked = 0;
      for (int i = 0; i < 16; i++) model[i] = 8'h00;
      sclk_q = sclk;
    end else if (cs_n) begin
      bit_cnt = 0;  // Byte framing restarts on select
      sclk_q  = sclk;
    end else begin
      if (sclk && !sclk_q) begin
        mosi_sr = {mosi_sr[6:0], mosi};
        miso_sr = {miso_sr[6:0], miso};
        bit_cnt++;
        if (bit_cnt == 8) begin
          bit_cnt = 0;
          handle_byte(mosi_sr, miso_sr);
        end
      end
      sclk_q = sclk;
    end
  end

endmodule

// File: tb_spi_wb.sv
module tb_spi_wb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_SWEEP  = 16;   // Reads of every register after reset
  localparam int N_TRANS  = 300;
  localparam int MAX_FILL = 12;   // Master stops polling here
  // Bytes per transaction times byte length, doubled
  localparam int TIMEOUT_CYCLES = (N_SWEEP + N_TRANS) * 12 * 64 * 2;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic sclk;
  logic cs_n;
  logic mosi;
  logic miso;
  int   cycle_cnt = 0;
  int   reads_sent = 0;
  int   value_errs;
  int   proto_errs;
  int   reads_checked;

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  spi_wb_top u_dut (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .sclk   (sclk),
    .cs_n   (cs_n),
    .mosi   (mosi),
    .miso   (miso)
  );

  tb_spi_wb_checker u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sclk          (sclk),
    .cs_n          (cs_n),
    .mosi          (mosi),
    .miso          (miso),
    .value_errs    (value_errs),
    .proto_errs    (proto_errs),
    .reads_checked (reads_checked)
  );

  // One mode 0 byte, 4 clk_i cycles per SCLK half period
  task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];  // Changes while SCLK is low
      repeat (4) @(negedge clk_i);
      sclk  = 1'b1;
      rx[i] = miso;
      repeat (4) @(negedge clk_i);
      sclk = 1'b0;
    end
  endtask

  task automatic send_idles(input int n);
    logic [7:0] rx;
    repeat (n) xfer_byte(8'h00, rx);
  endtask

  // Poll with fillers until the done marker comes back
  task automatic fill_until_done();
    logic [7:0] rx;
    int         n;
    n  = 0;
    rx = 8'h00;
    while (rx != spi_wb_pkg::BYTE_DONE && n < MAX_FILL) begin
      xfer_byte(8'h00, rx);
      n++;
    end
  endtask

  task automatic read_reg(input logic [7:0] adr_byte);
    logic [7:0] rx;
    logic [3:0] size;
    size = $urandom_range(1, 15);  // Non-zero so the command is not a filler
    xfer_byte({1'b0, 3'b000, size}, rx);
    xfer_byte(adr_byte, rx);
    fill_until_done();
    xfer_byte(8'h00, rx);  // Data comes back here
    xfer_byte(8'h00, rx);  // Closing filler
    reads_sent++;
  endtask

  task automatic write_reg(input logic [7:0] adr_byte, input logic [7:0] data);
    logic [7:0] rx;
    logic [3:0] size;
    size = $urandom_range(0, 15);
    xfer_byte({1'b1, 3'b000, size}, rx);
    xfer_byte(adr_byte, rx);
    xfer_byte(data, rx);
    fill_until_done();
  endtask

  initial begin
    void'($urandom(98406));
    rst_ni = 1'b0;
    sclk   = 1'b0;
    cs_n   = 1'b1;
    mosi   = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (4) @(negedge clk_i);
    cs_n = 1'b0;  // Selected for the whole run
    repeat (4) @(negedge clk_i);

    // Fresh registers read back as zero
    for (int i = 0; i < N_SWEEP; i++) begin
      send_idles($urandom_range(0, 2));
      read_reg({4'($urandom_range(0, 15)), 4'(i)});
    end

    // Mixed traffic, upper address bits random
    for (int n = 0; n < N_TRANS; n++) begin
      send_idles($urandom_range(0, 2));
      if ($urandom_range(0, 1) == 1) begin
        write_reg(8'($urandom_range(0, 255)), 8'($urandom_range(0, 255)));
      end else begin
        read_reg(8'($urandom_range(0, 255)));
      end
    end

    send_idles(2);  // Lets the last reply be seen
    repeat (8) @(negedge clk_i);
    cs_n = 1'b1;
    repeat (8) @(negedge clk_i);

    if (reads_checked != reads_sent) begin
      $display("The checker saw %0d read data bytes but %0d reads were sent",
               reads_checked, reads_sent);
    end
    $display("Errors: %0d value, %0d protocol; reads checked %0d of %0d",
             value_errs, proto_errs, reads_checked, reads_sent);
    if (value_errs == 0 && proto_errs == 0 && reads_checked == reads_sent) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Run stopped after %0d cycles without finishing the transactions", cycle_cnt);
    $display("Something failed");
    $finish;
  end

endmodule

// File: sources.f
spi_wb_pkg.sv
spi_byte_slave.sv
wb_cmd_ctrl.sv
wb_reg_bank.sv
spi_wb_top.sv
tb_spi_wb_checker.sv
tb_spi_wb.sv
